/* list.f */
+incdir+tb
source/leaf_pkg.sv
source/stream_fifo.sv
source/input_router.sv
source/output_arbiter.sv
source/leaf_interface.sv
source/user_kernel.sv
source/leaf_i5o2.sv
tb/tb_leaf_i5o2.sv

/* run.sh */
#!/usr/bin/env bash
# build the leaf testbench with verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_leaf_i5o2 -o tb_leaf_i5o2 \
    && ./obj_dir/tb_leaf_i5o2 | tee sim.log

grep -qx "TESTBENCH PASSED" sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

/* tb/leaf_model.svh */
`ifndef LEAF_MODEL_SVH
`define LEAF_MODEL_SVH

// words still waiting for their partners, one queue per user input
leaf_pkg::word_t pending [leaf_pkg::num_in_ports][$];
// packets each output stream still owes the network
leaf_pkg::packet_t expected [leaf_pkg::num_out_ports][$];
leaf_pkg::dest_t model_dest [leaf_pkg::num_out_ports] = '{default: '0};
logic [leaf_pkg::addr_bits-1:0] model_addr [leaf_pkg::num_out_ports] = '{default: '0};

function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state ^ (state << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
endfunction

task automatic expect_word(input int src, input leaf_pkg::word_t word);
    leaf_pkg::packet_t pkt;
    pkt.vld = 1'b1;
    pkt.leaf = model_dest[src].leaf;
    pkt.port = model_dest[src].port;
    pkt.addr = model_addr[src];
    pkt.payload = word;
    expected[src].push_back(pkt);
    // 7 bit counter, rolls over after 127
    model_addr[src] = model_addr[src] + 1'b1;
endtask

// update the model with a packet the leaf has taken
task automatic model_accept(input leaf_pkg::packet_t pkt);
    leaf_pkg::config_word_t cfg;
    leaf_pkg::word_t a;
    leaf_pkg::word_t b;
    leaf_pkg::word_t c;
    cfg = leaf_pkg::config_word_t'(pkt.payload);
    if (pkt.port == '0) begin
        model_dest[cfg.out_index].leaf = cfg.leaf;
        model_dest[cfg.out_index].port = cfg.port;
    end else if (int'(pkt.port) <= leaf_pkg::num_in_ports) begin
        pending[int'(pkt.port) - 1].push_back(pkt.payload);
    end
    // ports 6 to 15 leave no trace
    if (pending[0].size() > 0 && pending[1].size() > 0) begin
        a = pending[0].pop_front();
        b = pending[1].pop_front();
        expect_word(0, leaf_pkg::word_t'(a + b));
    end
    if (pending[2].size() > 0 && pending[3].size() > 0 && pending[4].size() > 0) begin
        a = pending[2].pop_front();
        b = pending[3].pop_front();
        c = pending[4].pop_front();
        expect_word(1, a ^ b ^ c);
    end
endtask

task automatic check_packet(input leaf_pkg::packet_t got, input leaf_pkg::packet_t exp,
                            input string what);
    if (got !== exp) begin
        $display("[ERROR] %0t: %s got vld %b leaf %0d port %0d addr %0d payload %h",
                 $time, what, got.vld, got.leaf, got.port, got.addr, got.payload);
        $display("[ERROR] %0t: %s expected vld %b leaf %0d port %0d addr %0d payload %h",
                 $time, what, exp.vld, exp.leaf, exp.port, exp.addr, exp.payload);
        stop_run();
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        stop_run();
    end
endtask

// the destination tells which output stream a packet came from
task automatic take_output(input leaf_pkg::packet_t got);
    int src;
    src = 1;
    if (expected[0].size() > 0 && got.leaf == model_dest[0].leaf
            && got.port == model_dest[0].port) begin
        src = 0;
    end
    if (expected[src].size() == 0) begin
        $display("an output packet to leaf %0d port %0d arrived that no input explains",
                 got.leaf, got.port);
        stop_run();
    end else begin
        check_packet(got, expected[src].pop_front(), $sformatf("output %0d packet", src + 1));
    end
endtask

`endif

/* tb/tb_leaf_i5o2.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_leaf_i5o2;

    localparam int fifo_depth = 4;
    localparam int clk_period = 4;
    localparam int pre_pairs = 6;
    localparam int num_groups = 480;
    // generous bound on cycles per input packet with stalls included
    localparam int slack_cycles = 40;
    localparam int total_packets = pre_pairs * 2 + 2 + num_groups * 3;
    localparam int timeout_ns = (total_packets * slack_cycles + 200) * clk_period;

    logic clk;
    logic reset;
    leaf_pkg::packet_t bft_in;
    logic bft_in_valid;
    logic bft_in_ready;
    leaf_pkg::packet_t bft_out;
    logic bft_out_valid;
    logic bft_out_ready;

    logic [31:0] stim_state;
    logic [31:0] stall_state;
    logic stalls_on;

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    `include "leaf_model.svh"

    leaf_i5o2 #(
        .fifo_depth(fifo_depth)
    ) dut_i (
        .clk(clk),
        .reset(reset),
        .bft_in(bft_in),
        .bft_in_valid(bft_in_valid),
        .bft_in_ready(bft_in_ready),
        .bft_out(bft_out),
        .bft_out_valid(bft_out_valid),
        .bft_out_ready(bft_out_ready)
    );

    function automatic logic [31:0] next_rand();
        stim_state = xorshift(stim_state);
        return stim_state;
    endfunction

    function automatic leaf_pkg::packet_t make_packet(input int port, input leaf_pkg::word_t word);
        leaf_pkg::packet_t pkt;
        pkt.vld = 1'b1;
        pkt.leaf = next_rand() % 32;
        pkt.port = leaf_pkg::port_bits'(port);
        pkt.addr = next_rand() % 128;
        pkt.payload = word;
        return pkt;
    endfunction

    // hold the packet until the leaf takes it and then maybe leave a gap
    task automatic send_packet(input leaf_pkg::packet_t pkt);
        int gap;
        @(negedge clk);
        bft_in = pkt;
        bft_in_valid = 1'b1;
        #1;
        while (!bft_in_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        model_accept(pkt);
        gap = int'(next_rand() % 8);
        if (gap < 2) begin
            @(negedge clk);
            bft_in_valid = 1'b0;
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic send_config(input logic out_index, input leaf_pkg::dest_t dest);
        leaf_pkg::config_word_t cw;
        cw = leaf_pkg::config_word_t'(next_rand());
        cw.out_index = out_index;
        cw.leaf = dest.leaf;
        cw.port = dest.port;
        send_packet(make_packet(0, leaf_pkg::word_t'(cw)));
    endtask

    // whole pairs and triples only so no input fifo waits forever on a partner
    task automatic send_group(input int kind);
        int first;
        if (kind < 3) begin
            first = int'(next_rand() % 2);
            send_packet(make_packet(1 + first, next_rand()));
            send_packet(make_packet(2 - first, next_rand()));
        end else if (kind < 6) begin
            first = int'(next_rand() % 3);
            for (int k = 0; k < 3; k++) begin
                send_packet(make_packet(3 + (first + k) % 3, next_rand()));
            end
        end else if (kind == 6) begin
            send_packet(make_packet(6 + int'(next_rand() % 10), next_rand()));
        end else begin
            @(negedge clk);
            bft_in_valid = 1'b0;
        end
    endtask

    task automatic wait_drained();
        @(negedge clk);
        bft_in_valid = 1'b0;
        while (expected[0].size() != 0 || expected[1].size() != 0) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2);
            clk = ~clk;
        end
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the expected output packets did not all arrive in time");
        stop_run();
    end

    // network side sink with random back-pressure once enabled
    initial begin
        bft_out_ready = 1'b0;
        stall_state = ~32'h4348;
        forever begin
            @(negedge clk);
            stall_state = xorshift(stall_state);
            bft_out_ready = stalls_on ? (stall_state[1:0] != 2'b00) : !reset;
            #1;
            if (!reset && bft_out_valid && bft_out_ready) begin
                take_output(bft_out);
            end
        end
    end

    initial begin
        leaf_pkg::dest_t dest_a;
        leaf_pkg::dest_t dest_b;
        logic [31:0] r;
        reset = 1'b1;
        bft_in = '0;
        bft_in_valid = 1'b0;
        stim_state = 32'h4348;
        stalls_on = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        repeat (5) begin
            @(negedge clk);
            #1;
            check_flag(bft_out_valid, 1'b0, "bft_out_valid after reset");
            check_flag(bft_in_ready, 1'b1, "bft_in_ready after reset");
        end

        // sums leave with the reset destination before any config
        for (int i = 0; i < pre_pairs; i++) begin
            send_group(0);
        end
        wait_drained();

        r = next_rand();
        dest_a.leaf = r[4:0];
        dest_a.port = r[8:5] | 4'd1;
        dest_b.leaf = dest_a.leaf + 5'd1;
        dest_b.port = r[12:9];
        send_config(1'b0, dest_a);
        send_config(1'b1, dest_b);

        stalls_on = 1'b1;
        for (int i = 0; i < num_groups; i++) begin
            send_group(int'(next_rand() % 8));
        end
        wait_drained();
        repeat (20) @(negedge clk);
        check_flag(bft_out_valid, 1'b0, "bft_out_valid after drain");

        $display("address counters ended at %0d and %0d", model_addr[0], model_addr[1]);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* source/leaf_i5o2.sv */
`timescale 1ns/10ps
`default_nettype none

module leaf_i5o2 #(
    parameter int fifo_depth = 4
) (
    input wire clk,
    input wire reset,

    input wire leaf_pkg::packet_t bft_in,
    input wire bft_in_valid,
    output wire bft_in_ready,
    output wire leaf_pkg::packet_t bft_out,
    output wire bft_out_valid,
    input wire bft_out_ready
);

    wire leaf_pkg::word_t to_user_data [leaf_pkg::num_in_ports];
    wire [leaf_pkg::num_in_ports-1:0] to_user_valid;
    wire [leaf_pkg::num_in_ports-1:0] to_user_ready;

    wire leaf_pkg::word_t from_user_data [leaf_pkg::num_out_ports];
    wire [leaf_pkg::num_out_ports-1:0] from_user_valid;
    wire [leaf_pkg::num_out_ports-1:0] from_user_ready;

    leaf_interface #(
        .fifo_depth(fifo_depth)
    ) leaf_interface_i (
        .clk(clk),
        .reset(reset),
        .bft_in(bft_in),
        .bft_in_valid(bft_in_valid),
        .bft_in_ready(bft_in_ready),
        .bft_out(bft_out),
        .bft_out_valid(bft_out_valid),
        .bft_out_ready(bft_out_ready),
        .to_user_data(to_user_data),
        .to_user_valid(to_user_valid),
        .to_user_ready(to_user_ready),
        .from_user_data(from_user_data),
        .from_user_valid(from_user_valid),
        .from_user_ready(from_user_ready)
    );

    user_kernel user_kernel_i (
        .clk(clk),
        .reset(reset),
        .in_data(to_user_data),
        .in_valid(to_user_valid),
        .in_ready(to_user_ready),
        .out_data(from_user_data),
        .out_valid(from_user_valid),
        .out_ready(from_user_ready)
    );

endmodule

`default_nettype wire

/* source/user_kernel.sv */
`timescale 1ns/10ps
`default_nettype none

module user_kernel (
    input wire clk,
    input wire reset,

    input wire leaf_pkg::word_t in_data [leaf_pkg::num_in_ports],
    input wire [leaf_pkg::num_in_ports-1:0] in_valid,
    output logic [leaf_pkg::num_in_ports-1:0] in_ready,

    output leaf_pkg::word_t out_data [leaf_pkg::num_out_ports],
    output logic [leaf_pkg::num_out_ports-1:0] out_valid,
    input wire [leaf_pkg::num_out_ports-1:0] out_ready
);

    logic [leaf_pkg::num_out_ports-1:0] out_free;
    logic sum_go;
    logic xor_go;

    // one-entry output register is empty or being taken
    assign out_free = ~out_valid | out_ready;

    // inputs 1 and 2 feed the adder, 3 to 5 the xor
    assign sum_go = in_valid[0] && in_valid[1] && out_free[0];
    assign xor_go = in_valid[2] && in_valid[3] && in_valid[4] && out_free[1];

    assign in_ready = {xor_go, xor_go, xor_go, sum_go, sum_go};

    always_ff @(posedge clk) begin
        if (sum_go) begin
            out_data[0] <= in_data[0] + in_data[1];
        end
        if (xor_go) begin
            out_data[1] <= in_data[2] ^ in_data[3] ^ in_data[4];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= '0;
        end else begin
            if (sum_go) begin
                out_valid[0] <= 1'b1;
            end else if (out_ready[0]) begin
                out_valid[0] <= 1'b0;
            end
            if (xor_go) begin
                out_valid[1] <= 1'b1;
            end else if (out_ready[1]) begin
                out_valid[1] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/leaf_interface.sv */
`timescale 1ns/10ps
`default_nettype none

module leaf_interface #(
    parameter int fifo_depth = 4
) (
    input wire clk,
    input wire reset,

    // network side
    input wire leaf_pkg::packet_t bft_in,
    input wire bft_in_valid,
    output logic bft_in_ready,
    output leaf_pkg::packet_t bft_out,
    output logic bft_out_valid,
    input wire bft_out_ready,

    // kernel input streams
    output leaf_pkg::word_t to_user_data [leaf_pkg::num_in_ports],
    output logic [leaf_pkg::num_in_ports-1:0] to_user_valid,
    input wire [leaf_pkg::num_in_ports-1:0] to_user_ready,

    // kernel output streams
    input wire leaf_pkg::word_t from_user_data [leaf_pkg::num_out_ports],
    input wire [leaf_pkg::num_out_ports-1:0] from_user_valid,
    output logic [leaf_pkg::num_out_ports-1:0] from_user_ready
);

    leaf_pkg::word_t router_data [leaf_pkg::num_in_ports];
    logic [leaf_pkg::num_in_ports-1:0] router_valid;
    logic [leaf_pkg::num_in_ports-1:0] router_ready;

    leaf_pkg::word_t arb_data [leaf_pkg::num_out_ports];
    logic [leaf_pkg::num_out_ports-1:0] arb_valid;
    logic [leaf_pkg::num_out_ports-1:0] arb_ready;

    leaf_pkg::dest_t dest_table [leaf_pkg::num_out_ports];

    input_router input_router_i (
        .clk(clk),
        .reset(reset),
        .bft_in(bft_in),
        .bft_in_valid(bft_in_valid),
        .bft_in_ready(bft_in_ready),
        .word_data(router_data),
        .word_valid(router_valid),
        .word_ready(router_ready),
        .dest_table(dest_table)
    );

    for (genvar i = 0; i < leaf_pkg::num_in_ports; i++) begin : g_in_fifo
        stream_fifo #(
            .item_t(leaf_pkg::word_t),
            .depth(fifo_depth)
        ) in_fifo_i (
            .clk(clk),
            .reset(reset),
            .in_data(router_data[i]),
            .in_valid(router_valid[i]),
            .in_ready(router_ready[i]),
            .out_data(to_user_data[i]),
            .out_valid(to_user_valid[i]),
            .out_ready(to_user_ready[i])
        );
    end

    // kernel results wait here until the arbiter picks them
    for (genvar i = 0; i < leaf_pkg::num_out_ports; i++) begin : g_out_fifo
        stream_fifo #(
            .item_t(leaf_pkg::word_t),
            .depth(fifo_depth)
        ) out_fifo_i (
            .clk(clk),
            .reset(reset),
            .in_data(from_user_data[i]),
            .in_valid(from_user_valid[i]),
            .in_ready(from_user_ready[i]),
            .out_data(arb_data[i]),
            .out_valid(arb_valid[i]),
            .out_ready(arb_ready[i])
        );
    end

    output_arbiter output_arbiter_i (
        .clk(clk),
        .reset(reset),
        .word_data(arb_data),
        .word_valid(arb_valid),
        .word_ready(arb_ready),
        .dest_table(dest_table),
        .bft_out(bft_out),
        .bft_out_valid(bft_out_valid),
        .bft_out_ready(bft_out_ready)
    );

endmodule

`default_nettype wire

/* source/output_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module output_arbiter (
    input wire clk,
    input wire reset,

    // words from the user output fifos
    input wire leaf_pkg::word_t word_data [leaf_pkg::num_out_ports],
    input wire [leaf_pkg::num_out_ports-1:0] word_valid,
    output logic [leaf_pkg::num_out_ports-1:0] word_ready,

    input wire leaf_pkg::dest_t dest_table [leaf_pkg::num_out_ports],

    // packets towards the tree network
    output leaf_pkg::packet_t bft_out,
    output logic bft_out_valid,
    input wire bft_out_ready
);

    localparam int sel_bits = $clog2(leaf_pkg::num_out_ports);

    typedef logic [sel_bits-1:0] sel_t;

    sel_t rr_ptr;
    sel_t grant;
    logic grant_valid;
    logic load_en;
    logic load;

    logic [leaf_pkg::addr_bits-1:0] addr_cnt [leaf_pkg::num_out_ports];
    leaf_pkg::packet_t out_reg;
    logic out_full;

    // scan from the pointer onwards, the lowest offset with data wins
    always_comb begin
        int idx;
        grant = rr_ptr;
        grant_valid = 1'b0;
        for (int k = leaf_pkg::num_out_ports - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % leaf_pkg::num_out_ports;
            if (word_valid[idx]) begin
                grant = sel_t'(idx);
                grant_valid = 1'b1;
            end
        end
    end

    // register is free or drains this cycle
    assign load_en = !out_full || bft_out_ready;
    assign load = load_en && grant_valid;

    always_comb begin
        for (int i = 0; i < leaf_pkg::num_out_ports; i++) begin
            word_ready[i] = load && (int'(grant) == i);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_reg.vld <= 1'b1;
            out_reg.leaf <= dest_table[grant].leaf;
            out_reg.port <= dest_table[grant].port;
            out_reg.addr <= addr_cnt[grant];
            out_reg.payload <= word_data[grant];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_full <= 1'b0;
            rr_ptr <= '0;
            for (int i = 0; i < leaf_pkg::num_out_ports; i++) begin
                addr_cnt[i] <= '0;
            end
        end else begin
            if (load) begin
                out_full <= 1'b1;
                rr_ptr <= sel_t'((int'(grant) + 1) % leaf_pkg::num_out_ports);
                addr_cnt[grant] <= addr_cnt[grant] + 1'b1;
            end else if (bft_out_ready) begin
                out_full <= 1'b0;
            end
        end
    end

    assign bft_out = out_reg;
    assign bft_out_valid = out_full;

    out_stable_on_stall: assert property (@(posedge clk) disable iff (reset)
        (bft_out_valid && !bft_out_ready) |=> (bft_out_valid && $stable(bft_out)));

endmodule

`default_nettype wire

/* source/input_router.sv */
`timescale 1ns/10ps
`default_nettype none

module input_router (
    input wire clk,
    input wire reset,

    // packets from the tree network
    input wire leaf_pkg::packet_t bft_in,
    input wire bft_in_valid,
    output logic bft_in_ready,

    // payloads towards the user input fifos
    output leaf_pkg::word_t word_data [leaf_pkg::num_in_ports],
    output logic [leaf_pkg::num_in_ports-1:0] word_valid,
    input wire [leaf_pkg::num_in_ports-1:0] word_ready,

    // destinations for the output streams
    output leaf_pkg::dest_t dest_table [leaf_pkg::num_out_ports]
);

    leaf_pkg::config_word_t cfg;
    leaf_pkg::dest_t cfg_entry;
    logic [leaf_pkg::num_in_ports-1:0] hit;
    logic is_config;
    logic config_fire;

    assign cfg = leaf_pkg::config_word_t'(bft_in.payload);
    assign cfg_entry.leaf = cfg.leaf;
    assign cfg_entry.port = cfg.port;

    assign is_config = (bft_in.port == '0);
    assign config_fire = bft_in_valid && is_config;

    // user port n maps onto fifo n-1
    always_comb begin
        for (int i = 0; i < leaf_pkg::num_in_ports; i++) begin
            hit[i] = (bft_in.port == leaf_pkg::port_bits'(i + 1));
        end
    end

    always_comb begin
        for (int i = 0; i < leaf_pkg::num_in_ports; i++) begin
            word_data[i] = bft_in.payload;
            word_valid[i] = bft_in_valid && hit[i];
        end
    end

    // config and unknown ports are always taken and unknown ones go nowhere
    assign bft_in_ready = (|hit) ? |(hit & word_ready) : 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < leaf_pkg::num_out_ports; i++) begin
                dest_table[i] <= '0;
            end
        end else if (config_fire) begin
            dest_table[cfg.out_index] <= cfg_entry;
        end
    end

    word_valid_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(word_valid));

endmodule

`default_nettype wire

/* source/stream_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
    parameter type item_t = logic [31:0],
    parameter int depth = 4
) (
    input wire clk,
    input wire reset,

    input wire item_t in_data,
    input wire in_valid,
    output logic in_ready,

    output item_t out_data,
    output logic out_valid,
    input wire out_ready
);

    localparam int ptr_bits = $clog2(depth);
    localparam logic [ptr_bits:0] full_count = (ptr_bits + 1)'(depth);

    item_t mem [depth];

    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits:0] count;
    logic do_write;
    logic do_read;

    assign in_ready = (count != full_count);
    assign out_valid = (count != '0);
    assign out_data = mem[rd_ptr];

    assign do_write = in_valid && in_ready;
    assign do_read = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap naturally since depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    count_no_overflow: assert property (@(posedge clk) disable iff (reset)
        count <= full_count);

    // an empty fifo can gain at most one entry and never wraps below zero
    count_no_underflow: assert property (@(posedge clk) disable iff (reset)
        (count == '0) |=> (count <= (ptr_bits + 1)'(1)));

endmodule

`default_nettype wire

/* source/leaf_pkg.sv */
`default_nettype none

package leaf_pkg;

    // network packet field widths
    localparam int payload_bits = 32;
    localparam int leaf_bits = 5;
    localparam int port_bits = 4;
    localparam int addr_bits = 7;

    // user streams on the kernel side
    localparam int num_in_ports = 5;
    localparam int num_out_ports = 2;

    // one user payload word
    typedef logic [payload_bits-1:0] word_t;

    // 49 bit network packet, msb first
    typedef struct packed {
        logic                 vld;
        logic [leaf_bits-1:0] leaf;
        logic [port_bits-1:0] port;
        logic [addr_bits-1:0] addr;
        word_t                payload;
    } packet_t;

    // one entry of the destination table
    typedef struct packed {
        logic [leaf_bits-1:0] leaf;
        logic [port_bits-1:0] port;
    } dest_t;

    // payload layout of a packet sent to port 0
    // out_index picks the output stream whose destination is written
    typedef struct packed {
        logic                                          out_index;
        logic [leaf_bits-1:0]                          leaf;
        logic [port_bits-1:0]                          port;
        logic [payload_bits-1-leaf_bits-port_bits-1:0] unused;
    } config_word_t;

endpackage

`default_nettype wire
